// ==== build.f ====
+incdir+src
src/ifu_pkg.sv
src/inst_sram.sv
src/inst_fetch.sv
src/ifu_top.sv
tests/ifu_chk.sv
tests/ifu_tb.sv

// ==== run.sh ====
#!/bin/sh
# compile and run the fetch path testbench with verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --top-module ifu_tb -f build.f -o ifu_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/ifu_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "tests failed" "$LOG"; then
    echo "FAIL"
    exit 1
fi

echo "PASS"
exit 0

// ==== src/ifu_params.svh ====
`ifndef IFU_PARAMS_SVH
`define IFU_PARAMS_SVH

// address and data width of the fetch path
`define IF_XLEN 32

// instruction sram size in 32-bit words
`define INST_SRAM_DEPTH 256

// wait cycles from the read address handshake to rvalid
// must be 1 or more
`define INST_SRAM_RD_LAT 2

`endif

// ==== src/ifu_pkg.sv ====
`include "ifu_params.svh"

package ifu_pkg;

    // axi-lite response codes, only okay and slverr are produced
    typedef enum logic [1:0] {
        resp_okay   = 2'b00,
        resp_slverr = 2'b10
    } axi_resp_e;

    // fetch unit read master
    typedef enum logic {
        rd_idle,
        rd_busy
    } rd_state_e;

    // sram port arbitration and response states
    typedef enum logic [1:0] {
        sram_idle,
        sram_wait,
        sram_resp,
        sram_wresp
    } sram_state_e;

    typedef struct packed {
        logic [`IF_XLEN-1:0] addr;
    } axi_ar_t;

    typedef struct packed {
        logic [`IF_XLEN-1:0] data;
        axi_resp_e           resp;
    } axi_r_t;

    // load write, address and data share one valid
    typedef struct packed {
        logic [`IF_XLEN-1:0]   addr;
        logic [`IF_XLEN-1:0]   data;
        logic [`IF_XLEN/8-1:0] strb;
    } axi_w_t;

    typedef struct packed {
        axi_resp_e resp;
    } axi_b_t;

endpackage

// ==== src/ifu_top.sv ====
`include "ifu_params.svh"

module ifu_top (
    input  logic                clk,
    input  logic                rst,
    // pc source
    input  logic [`IF_XLEN-1:0] pc,
    // fetched instruction towards decode
    output logic [`IF_XLEN-1:0] inst,
    output logic                inst_fault,
    output logic                inst_valid,
    // program load channel
    input  ifu_pkg::axi_w_t     w,
    input  logic                wvalid,
    output logic                wready,
    output ifu_pkg::axi_b_t     b,
    output logic                bvalid,
    input  logic                bready
);

    inst_fetch u_fetch (
        .clk        (clk),
        .rst        (rst),
        .pc         (pc),
        .inst       (inst),
        .inst_fault (inst_fault),
        .inst_valid (inst_valid),
        .w          (w),
        .wvalid     (wvalid),
        .wready     (wready),
        .b          (b),
        .bvalid     (bvalid),
        .bready     (bready)
    );

endmodule

// ==== src/inst_fetch.sv ====
`include "ifu_params.svh"

module inst_fetch (
    input  logic                clk,
    input  logic                rst,
    input  logic [`IF_XLEN-1:0] pc,
    output logic [`IF_XLEN-1:0] inst,
    output logic                inst_fault,
    output logic                inst_valid,
    input  ifu_pkg::axi_w_t     w,
    input  logic                wvalid,
    output logic                wready,
    output ifu_pkg::axi_b_t     b,
    output logic                bvalid,
    input  logic                bready
);
    import ifu_pkg::*;

    rd_state_e           rd_state;
    logic [`IF_XLEN-1:0] stored_pc;
    logic                pc_valid;
    logic                pc_match;

    axi_ar_t ar;
    logic    arvalid;
    logic    arready;
    axi_r_t  r;
    logic    rvalid;
    logic    rready;

    // stored pc still matches the pc source
    assign pc_match = pc_valid && (pc == stored_pc);

    // new read whenever the pc moved while idle
    assign arvalid = (rd_state == rd_idle) && !pc_match;
    assign ar      = '{addr: pc};
    assign rready  = (rd_state == rd_busy);

    // drops in the same cycle as a pc change
    assign inst_valid = (rd_state == rd_idle) && pc_match;

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_state  <= rd_idle;
            pc_valid  <= 1'b0;
            stored_pc <= '0;
        end else begin
            case (rd_state)
                rd_idle: begin
                    if (arvalid && arready) begin
                        stored_pc <= pc;
                        pc_valid  <= 1'b1;
                        rd_state  <= rd_busy;
                    end
                end
                rd_busy: begin
                    if (rvalid && rready) begin
                        rd_state <= rd_idle;
                    end
                end
                default: rd_state <= rd_idle;
            endcase
        end
    end

    // instruction and fault captured at the data handshake
    always_ff @(posedge clk) begin
        if (rvalid && rready) begin
            inst       <= r.data;
            inst_fault <= (r.resp != resp_okay);
        end
    end

    inst_sram #(
        .DEPTH  (`INST_SRAM_DEPTH),
        .RD_LAT (`INST_SRAM_RD_LAT)
    ) u_sram (
        .clk     (clk),
        .rst     (rst),
        .ar      (ar),
        .arvalid (arvalid),
        .arready (arready),
        .r       (r),
        .rvalid  (rvalid),
        .rready  (rready),
        .w       (w),
        .wvalid  (wvalid),
        .wready  (wready),
        .b       (b),
        .bvalid  (bvalid),
        .bready  (bready)
    );

endmodule

// ==== src/inst_sram.sv ====
`include "ifu_params.svh"

module inst_sram #(
    parameter int DEPTH  = `INST_SRAM_DEPTH,
    parameter int RD_LAT = `INST_SRAM_RD_LAT
) (
    input  logic             clk,
    input  logic             rst,
    input  ifu_pkg::axi_ar_t ar,
    input  logic             arvalid,
    output logic             arready,
    output ifu_pkg::axi_r_t  r,
    output logic             rvalid,
    input  logic             rready,
    input  ifu_pkg::axi_w_t  w,
    input  logic             wvalid,
    output logic             wready,
    output ifu_pkg::axi_b_t  b,
    output logic             bvalid,
    input  logic             bready
);
    import ifu_pkg::*;

    localparam int XLEN   = `IF_XLEN;
    localparam int STRB_W = XLEN / 8;
    localparam int IDX_W  = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W  = (RD_LAT > 2) ? $clog2(RD_LAT - 1) : 1;

    // counter start so that rvalid lands RD_LAT cycles after the handshake
    localparam logic [CNT_W-1:0] CNT_INIT   = (RD_LAT > 1) ? CNT_W'(RD_LAT - 2) : '0;
    localparam logic [XLEN-1:0]  ADDR_LIMIT = XLEN'(DEPTH * 4);

    sram_state_e      state;
    logic [CNT_W-1:0] wait_cnt;
    logic [XLEN-1:0]  rd_addr;
    logic [XLEN-1:0]  mem_addr;
    logic [IDX_W-1:0] mem_idx;
    logic             in_range;
    logic             ar_hs;
    logic             w_hs;
    logic             rd_load;

    logic [XLEN-1:0] mem [DEPTH];

    assign arready = (state == sram_idle);
    // a pending read takes the port ahead of a load write
    assign wready  = (state == sram_idle) && !arvalid;
    assign rvalid  = (state == sram_resp);
    assign bvalid  = (state == sram_wresp);

    assign ar_hs = arvalid && arready;
    assign w_hs  = wvalid && wready;

    // single address for the one array port
    always_comb begin
        if (state != sram_idle) begin
            mem_addr = rd_addr;
        end else if (arvalid) begin
            mem_addr = ar.addr;
        end else begin
            mem_addr = w.addr;
        end
    end

    assign mem_idx  = mem_addr[IDX_W+1:2];
    assign in_range = (mem_addr < ADDR_LIMIT);

    // array read happens on the edge that enters sram_resp
    assign rd_load = ((RD_LAT == 1) && ar_hs) ||
                     ((state == sram_wait) && (wait_cnt == '0));

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= sram_idle;
            wait_cnt <= '0;
        end else begin
            case (state)
                sram_idle: begin
                    if (ar_hs) begin
                        wait_cnt <= CNT_INIT;
                        state    <= (RD_LAT == 1) ? sram_resp : sram_wait;
                    end else if (w_hs) begin
                        state <= sram_wresp;
                    end
                end
                sram_wait: begin
                    if (wait_cnt == '0) begin
                        state <= sram_resp;
                    end else begin
                        wait_cnt <= wait_cnt - 1'b1;
                    end
                end
                sram_resp: begin
                    if (rready) begin
                        state <= sram_idle;
                    end
                end
                sram_wresp: begin
                    if (bready) begin
                        state <= sram_idle;
                    end
                end
                default: state <= sram_idle;
            endcase
        end
    end

    // read address held through the wait states
    always_ff @(posedge clk) begin
        if (ar_hs) begin
            rd_addr <= ar.addr;
        end
    end

    always_ff @(posedge clk) begin
        // byte lane writes, out of range loads are dropped
        if (w_hs && in_range) begin
            for (int i = 0; i < STRB_W; i++) begin
                if (w.strb[i]) begin
                    mem[mem_idx][i*8 +: 8] <= w.data[i*8 +: 8];
                end
            end
        end
        if (rd_load) begin
            r.data <= in_range ? mem[mem_idx] : '0;
            r.resp <= in_range ? resp_okay : resp_slverr;
        end
        if (w_hs) begin
            b.resp <= in_range ? resp_okay : resp_slverr;
        end
    end

endmodule

// ==== tests/ifu_chk.sv ====
module ifu_chk (
    input logic                clk,
    input logic                rst,
    input ifu_pkg::axi_ar_t    ar,
    input logic                arvalid,
    input logic                arready,
    input ifu_pkg::axi_r_t     r,
    input logic                rvalid,
    input logic                rready,
    input logic                inst_valid,
    input ifu_pkg::rd_state_e  rd_state
);
    timeunit 1ns;
    timeprecision 100ps;
    import ifu_pkg::*;

    // read request held until the sram takes it
    ar_hold: assert property (@(posedge clk) disable iff (rst)
        arvalid && !arready |=> arvalid && $stable(ar))
        else $error("read address dropped or changed before arready");

    // read data held until the fetch unit takes it
    r_hold: assert property (@(posedge clk) disable iff (rst)
        rvalid && !rready |=> rvalid && $stable(r))
        else $error("read data dropped or changed before rready");

    // no instruction offered while a read is in flight
    valid_idle: assert property (@(posedge clk) disable iff (rst)
        !(inst_valid && rd_state == rd_busy))
        else $error("inst_valid high during an outstanding read");

endmodule

bind inst_fetch ifu_chk u_chk (
    .clk        (clk),
    .rst        (rst),
    .ar         (ar),
    .arvalid    (arvalid),
    .arready    (arready),
    .r          (r),
    .rvalid     (rvalid),
    .rready     (rready),
    .inst_valid (inst_valid),
    .rd_state   (rd_state)
);

// ==== tests/ifu_tb.sv ====
`include "ifu_params.svh"

module ifu_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import ifu_pkg::*;

    localparam int          TIMEOUT    = 200;
    localparam int          RD_LAT     = `INST_SRAM_RD_LAT;
    localparam int          IDX_W      = $clog2(`INST_SRAM_DEPTH);
    localparam logic [31:0] ADDR_LIMIT = 32'(`INST_SRAM_DEPTH * 4);
    localparam logic [31:0] SEED       = 32'h7238df61;
    localparam logic [31:0] RESET_PC   = 32'h0000_1000;
    localparam string       OP_WRITE   = "w";
    localparam string       OP_FETCH   = "f";

    logic                clk;
    logic                rst;
    logic [`IF_XLEN-1:0] pc;
    logic [`IF_XLEN-1:0] inst;
    logic                inst_fault;
    logic                inst_valid;
    axi_w_t              w;
    logic                wvalid;
    logic                wready;
    axi_b_t              b;
    logic                bvalid;
    logic                bready;

    // reference copy of the instruction memory
    logic [31:0] model [`INST_SRAM_DEPTH];
    int          value_errs;
    int          timeout_errs;
    int          vector_errs;
    bit          aborted;

    ifu_top uut (
        .clk        (clk),
        .rst        (rst),
        .pc         (pc),
        .inst       (inst),
        .inst_fault (inst_fault),
        .inst_valid (inst_valid),
        .w          (w),
        .wvalid     (wvalid),
        .wready     (wready),
        .b          (b),
        .bvalid     (bvalid),
        .bready     (bready)
    );

    always #5 clk = ~clk;

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        assert (got === exp) else begin
            value_errs++;
            $display("ERR %0t %s expected %h got %h", $time, name, exp, got);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        assert (got === exp) else begin
            value_errs++;
            $display("ERR %0t %s expected %b got %b", $time, name, exp, got);
        end
    endtask

    task automatic report_timeout(input string what);
        timeout_errs++;
        aborted = 1'b1;
        $display("timeout at %0t while waiting for %s", $time, what);
    endtask

    function automatic logic in_range(input logic [31:0] addr);
        return addr < ADDR_LIMIT;
    endfunction

    task automatic do_write(input logic [31:0] addr, input logic [31:0] data,
                            input logic [3:0] strb);
        int          cnt;
        int          hold;
        axi_resp_e   exp_resp;
        exp_resp = in_range(addr) ? resp_okay : resp_slverr;
        hold = ($urandom_range(0, 1) == 1) ? int'($urandom_range(1, 4)) : 0;
        @(posedge clk);
        w      <= '{addr: addr, data: data, strb: strb};
        wvalid <= 1'b1;
        cnt = 0;
        @(negedge clk);
        while (!wready) begin
            if (cnt == TIMEOUT) begin
                report_timeout("wready");
                return;
            end
            cnt++;
            @(negedge clk);
        end
        // no response before the handshake
        check_bit("bvalid", bvalid, 1'b0);
        // handshake edge
        @(posedge clk);
        wvalid <= 1'b0;
        if (hold > 0) begin
            bready <= 1'b0;
        end
        if (in_range(addr)) begin
            for (int i = 0; i < 4; i++) begin
                if (strb[i]) begin
                    model[addr[IDX_W+1:2]][i*8 +: 8] = data[i*8 +: 8];
                end
            end
        end
        @(negedge clk);
        check_bit("bvalid", bvalid, 1'b1);
        check_val("b.resp", 32'(b.resp), 32'(exp_resp));
        check_bit("wready", wready, 1'b0);
        if (hold > 0) begin
            // response held under back-pressure
            repeat (hold) begin
                @(negedge clk);
                check_bit("bvalid", bvalid, 1'b1);
                check_val("b.resp", 32'(b.resp), 32'(exp_resp));
            end
            @(posedge clk);
            bready <= 1'b1;
            @(negedge clk);
        end
        cnt = 0;
        while (!(bvalid && bready)) begin
            if (cnt == TIMEOUT) begin
                report_timeout("the write response");
                return;
            end
            cnt++;
            @(negedge clk);
        end
        @(posedge clk);
        @(negedge clk);
        check_bit("bvalid", bvalid, 1'b0);
        check_bit("wready", wready, 1'b1);
    endtask

    task automatic do_fetch(input logic [31:0] new_pc, input logic [31:0] exp_inst,
                            input logic exp_fault);
        int cnt;
        if (new_pc == pc) begin
            // steady pc, no new read
            repeat (4) begin
                @(negedge clk);
                check_bit("inst_valid", inst_valid, 1'b1);
                check_bit("arvalid", uut.u_fetch.arvalid, 1'b0);
            end
        end else begin
            @(posedge clk);
            pc <= new_pc;
            @(negedge clk);
            check_bit("inst_valid", inst_valid, 1'b0);
            cnt = 0;
            while (!inst_valid) begin
                if (cnt == TIMEOUT) begin
                    report_timeout("inst_valid");
                    return;
                end
                @(negedge clk);
                cnt++;
            end
            check_val("fetch latency", 32'(cnt), 32'(RD_LAT + 1));
        end
        check_val("inst", inst, exp_inst);
        check_bit("inst_fault", inst_fault, exp_fault);
    endtask

    initial begin
        int          fd;
        int          n;
        int          cnt;
        string       tok;
        string       line;
        logic [31:0] a;
        logic [31:0] d;
        logic [3:0]  s;
        logic [31:0] exp_inst;
        logic        exp_fault;
        logic [31:0] model_inst;

        clk = 1'b0;
        rst = 1'b1;
        pc = RESET_PC;
        w = '0;
        wvalid = 1'b0;
        bready = 1'b1;
        value_errs = 0;
        timeout_errs = 0;
        vector_errs = 0;
        aborted = 1'b0;
        void'($urandom(SEED));

        repeat (2) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_bit("inst_valid", inst_valid, 1'b0);
        check_bit("bvalid", bvalid, 1'b0);

        // first fetch of the out of range reset pc
        cnt = 0;
        while (!inst_valid && !aborted) begin
            if (cnt == TIMEOUT) begin
                report_timeout("the first fetch after reset");
            end
            cnt++;
            @(negedge clk);
        end
        check_val("inst", inst, 32'h0);
        check_bit("inst_fault", inst_fault, 1'b1);

        fd = $fopen("tests/ifu_vectors.txt", "r");
        if (fd == 0) begin
            vector_errs++;
            $display("could not open tests/ifu_vectors.txt");
        end else begin
            while (!aborted && !$feof(fd)) begin
                n = $fscanf(fd, "%s", tok);
                if (n != 1) begin
                    break;
                end
                if (tok.substr(0, 0) == "#") begin
                    n = $fgets(line, fd);
                end else if (tok == OP_WRITE) begin
                    n = $fscanf(fd, "%h %h %h", a, d, s);
                    if (n != 3) begin
                        vector_errs++;
                        $display("malformed write line in the vector file");
                    end else begin
                        repeat ($urandom_range(0, 3)) @(posedge clk);
                        do_write(a, d, s);
                    end
                end else if (tok == OP_FETCH) begin
                    n = $fscanf(fd, "%h %h %h", a, exp_inst, exp_fault);
                    if (n != 3) begin
                        vector_errs++;
                        $display("malformed fetch line in the vector file");
                    end else begin
                        model_inst = in_range(a) ? model[a[IDX_W+1:2]] : 32'h0;
                        assert (model_inst === exp_inst && exp_fault === !in_range(a)) else begin
                            vector_errs++;
                            $display("fetch vector for pc %h disagrees with the memory model", a);
                        end
                        repeat ($urandom_range(0, 3)) @(posedge clk);
                        do_fetch(a, exp_inst, exp_fault);
                    end
                end else begin
                    vector_errs++;
                    $display("unknown operation %s in the vector file", tok);
                end
            end
            $fclose(fd);
        end

        $display("errors: %0d value, %0d timeout, %0d vector",
                 value_errs, timeout_errs, vector_errs);
        if (value_errs + timeout_errs + vector_errs == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// ==== tests/ifu_vectors.txt ====
# w <addr> <data> <strb>   load write, all fields hex
# f <pc> <inst> <fault>    fetch with the expected instruction and fault flag
w 00000000 00000013 f
w 00000004 00100093 f
w 00000008 00208113 f
w 0000000c 00310193 f
w 00000010 00418213 f
w 00000014 fe5ff06f f
w 000003fc 0000006f f
f 00000000 00000013 0
f 00000004 00100093 0
f 00000004 00100093 0
f 00000008 00208113 0
f 0000000c 00310193 0
f 00000010 00418213 0
f 00000014 fe5ff06f 0
f 00000014 fe5ff06f 0
f 000003fc 0000006f 0
# out of range, word 0 must survive the aliased loads
f 00000400 00000000 1
w 00000400 deadbeef f
w 80000000 12345678 f
f 00000404 00000000 1
f 00000000 00000013 0
f 80000000 00000000 1
# byte lane merges
w 00000020 11223344 f
w 00000020 aabbccdd 1
w 00000020 00ee0000 4
f 00000020 11ee33dd 0
w 00000024 00000000 f
w 00000024 cafef00d c
w 00000024 12345678 2
f 00000024 cafe5600 0
w 00000020 ffffffff 0
f 00000020 11ee33dd 0
w 00000028 00000000 f
w 00000028 0000a0b7 3
w 00000028 12000000 8
f 00000028 1200a0b7 0
f 00000000 00000013 0
f 00000000 00000013 0
f 00001000 00000000 1
